// File: Makefile
TOP = tb_adc_periph

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+rtl
rtl/adc_bus_pkg.sv
rtl/sfr_bank.sv
rtl/drp_bridge.sv
rtl/adc_event_capture.sv
rtl/adc_periph.sv
testbench/adc_drp_model.sv
testbench/tb_adc_periph.sv

// File: rtl/adc_bus_config.svh
`ifndef ADC_BUS_CONFIG_SVH
`define ADC_BUS_CONFIG_SVH

// ------------------------------
// Address map
// ------------------------------
`define ADC_BASE_ADDR   8'h01   // Matched against addr[31:24]
`define ADC_WIN_DRP     8'h00   // Converter DRP window, addr[23:16]
`define ADC_WIN_SFR     8'h10   // Register bank window, addr[23:16]

// Register bank size in 32-bit words
`define ADC_SFR_REGS    3

// ------------------------------
// DRP geometry
// ------------------------------
`define ADC_DRP_AW      7       // DRP address bits
`define ADC_DRP_DW      16      // DRP data bits

`endif

// File: rtl/adc_bus_pkg.sv
`include "adc_bus_config.svh"

package adc_bus_pkg;

    // ------------------------------
    // Native memory bus
    // ------------------------------
    // CPU to peripheral, 69 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;     // All zero for a read
    } mem_fwd_t;

    // Peripheral to CPU, 33 bits
    // Idle blocks drive all zeros so replies can be ORed
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_ret_t;

    // ------------------------------
    // Converter DRP
    // ------------------------------
    typedef struct packed {
        logic                   den;    // One-cycle enable
        logic                   dwe;    // Write, only with den
        logic [`ADC_DRP_AW-1:0] daddr;
        logic [`ADC_DRP_DW-1:0] di;
    } drp_req_t;

    typedef struct packed {
        logic                   drdy;
        logic [`ADC_DRP_DW-1:0] dout;
    } drp_rsp_t;

    // Converter status outputs
    typedef struct packed {
        logic       busy;
        logic       eoc;    // End of conversion
        logic       eos;    // End of sequence
        logic       ot;     // Over-temperature
        logic [4:0] channel;
        logic [7:0] alm;
    } adc_status_t;

endpackage

// File: rtl/adc_event_capture.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module adc_event_capture (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              trigger_in,
    input  adc_bus_pkg::adc_status_t          adc_status,
    input  logic [31:0]                       reg_wdata,
    input  logic [`ADC_SFR_REGS-1:0]          reg_wstrb,
    output logic [`ADC_SFR_REGS-1:0][31:0]    reg_out,
    output logic                              convst,
    output logic                              adc_reset
);

    // ------------------------------
    // Trigger synchronizer
    // ------------------------------
    logic trig_m;
    logic trig_s;
    logic [31:0] ctrl_q;    // Word 2, bit 0 enables trigger

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_m <= 1'b0;
            trig_s <= 1'b0;
        end else begin
            trig_m <= trigger_in;   // First stage may go metastable
            trig_s <= trig_m;
        end
    end

    assign convst = trig_s && ctrl_q[0];

    // ------------------------------
    // Control, counter, soft reset
    // ------------------------------
    logic        eoc_d;
    logic        eoc_rise;
    logic [31:0] count_q;
    logic        adc_reset_q;

    assign eoc_rise = adc_status.eoc && !eoc_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q      <= 32'h0;
            eoc_d       <= 1'b0;
            count_q     <= 32'h0;
            adc_reset_q <= 1'b1;    // Converter held in reset with the system
        end else begin
            eoc_d       <= adc_status.eoc;
            adc_reset_q <= reg_wstrb[0] && reg_wdata[0];    // Soft reset pulse
            if (reg_wstrb[2]) begin
                ctrl_q <= reg_wdata;
            end
            if (reg_wstrb[1]) begin
                count_q <= 32'h0;               // Any write clears
            end else if (eoc_rise) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    assign adc_reset = adc_reset_q;

    // Word 0 status layout
    assign reg_out[0] = {8'h0, adc_status.alm, 3'h0, adc_status.channel,
                         4'h0, adc_status.ot, adc_status.eos,
                         adc_status.eoc, adc_status.busy};
    assign reg_out[1] = count_q;
    assign reg_out[2] = ctrl_q;

endmodule

// File: rtl/adc_periph.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module adc_periph (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      trigger_in,    // External conversion trigger
    input  adc_bus_pkg::mem_fwd_t     mem_fwd,
    output adc_bus_pkg::mem_ret_t     mem_ret,
    // Converter macro sits outside this level
    output adc_bus_pkg::drp_req_t     drp_req,
    input  adc_bus_pkg::drp_rsp_t     drp_rsp,
    input  adc_bus_pkg::adc_status_t  adc_status,
    output logic                      convst,
    output logic                      adc_reset
);

    import adc_bus_pkg::*;

    // ------------------------------
    // Bus replies
    // ------------------------------
    mem_ret_t sfr_ret;
    mem_ret_t drp_ret;

    // Idle blocks return zero, so OR merges them
    assign mem_ret = mem_ret_t'(sfr_ret | drp_ret);

    // Register bank to capture block
    logic [`ADC_SFR_REGS-1:0][31:0] reg_in;
    logic [31:0]                    reg_wdata;
    logic [`ADC_SFR_REGS-1:0]       reg_wstrb;

    // ------------------------------
    // Instances
    // ------------------------------
    sfr_bank #(
        .N_REGS    (`ADC_SFR_REGS)
    ) sfr_bank_i (
        .clk       (clk),
        .rst       (rst),
        .mem_fwd   (mem_fwd),
        .mem_ret   (sfr_ret),
        .reg_in    (reg_in),
        .reg_wdata (reg_wdata),
        .reg_wstrb (reg_wstrb)
    );

    drp_bridge drp_bridge_i (
        .clk       (clk),
        .rst       (rst),
        .mem_fwd   (mem_fwd),
        .mem_ret   (drp_ret),
        .drp_req   (drp_req),
        .drp_rsp   (drp_rsp)
    );

    adc_event_capture adc_event_capture_i (
        .clk        (clk),
        .rst        (rst),
        .trigger_in (trigger_in),
        .adc_status (adc_status),
        .reg_wdata  (reg_wdata),
        .reg_wstrb  (reg_wstrb),
        .reg_out    (reg_in),
        .convst     (convst),
        .adc_reset  (adc_reset)
    );

endmodule

// File: rtl/drp_bridge.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module drp_bridge (
    input  logic                  clk,
    input  logic                  rst,
    input  adc_bus_pkg::mem_fwd_t mem_fwd,
    output adc_bus_pkg::mem_ret_t mem_ret,
    output adc_bus_pkg::drp_req_t drp_req,
    input  adc_bus_pkg::drp_rsp_t drp_rsp
);

    typedef enum logic [1:0] {
        st_idle,    // Free for a new request
        st_wait,    // DRP access in flight
        st_reply    // Bus reply cycle
    } state_t;

    state_t state_q;

    // ------------------------------
    // Window decode
    // ------------------------------
    logic win_hit;
    logic full_wr;
    logic full_rd;
    logic accept;
    logic guard_q;  // One idle cycle after each reply

    assign win_hit = mem_fwd.valid &&
                     (mem_fwd.addr[31:16] == {`ADC_BASE_ADDR, `ADC_WIN_DRP});
    assign full_wr = &mem_fwd.wstrb;
    assign full_rd = ~|mem_fwd.wstrb;

    // One access outstanding at most
    assign accept = win_hit && (full_wr || full_rd) &&
                    (state_q == st_idle) && !guard_q;

    // ------------------------------
    // Controller
    // ------------------------------
    logic den_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
            guard_q <= 1'b0;
            den_q   <= 1'b0;
        end else begin
            den_q   <= 1'b0;    // Single pulse by default
            guard_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        den_q   <= 1'b1;    // den one cycle after acceptance
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (drp_rsp.drdy) begin
                        state_q <= st_reply;
                    end
                end
                st_reply: begin
                    state_q <= st_idle;
                    guard_q <= 1'b1;    // CPU still holds valid this edge
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // ------------------------------
    // Payload registers
    // ------------------------------
    logic                   write_q;
    logic [`ADC_DRP_AW-1:0] daddr_q;
    logic [`ADC_DRP_DW-1:0] di_q;
    logic [31:0]            rdata_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            write_q <= full_wr;
            daddr_q <= mem_fwd.addr[`ADC_DRP_AW+1:2];   // Word address
            di_q    <= mem_fwd.wdata[`ADC_DRP_DW-1:0];
        end
        if ((state_q == st_wait) && drp_rsp.drdy) begin
            // Write replies carry zero
            rdata_q <= write_q ? 32'h0 : {{(32-`ADC_DRP_DW){1'b0}}, drp_rsp.dout};
        end
    end

    // DRP side
    assign drp_req.den   = den_q;
    assign drp_req.dwe   = den_q && write_q;
    assign drp_req.daddr = daddr_q;
    assign drp_req.di    = di_q;

    // Bus side, quiet outside st_reply
    assign mem_ret.ready = (state_q == st_reply);
    assign mem_ret.rdata = (state_q == st_reply) ? rdata_q : 32'h0;

endmodule

// File: rtl/sfr_bank.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module sfr_bank #(
    parameter int N_REGS = `ADC_SFR_REGS
) (
    input  logic                          clk,
    input  logic                          rst,
    input  adc_bus_pkg::mem_fwd_t         mem_fwd,
    output adc_bus_pkg::mem_ret_t         mem_ret,
    input  logic [N_REGS-1:0][31:0]       reg_in,     // Read view of each word
    output logic [31:0]                   reg_wdata,
    output logic [N_REGS-1:0]             reg_wstrb   // One-cycle write pulse per word
);

    // Word index width, at least addr[3:2]
    localparam int IDX_W = (N_REGS > 4) ? $clog2(N_REGS) : 2;

    // ------------------------------
    // Window decode
    // ------------------------------
    logic             win_hit;
    logic             full_wr;
    logic             full_rd;
    logic             hit;
    logic             accept;
    logic [IDX_W-1:0] idx;

    assign win_hit = mem_fwd.valid &&
                     (mem_fwd.addr[31:16] == {`ADC_BASE_ADDR, `ADC_WIN_SFR});
    assign full_wr = &mem_fwd.wstrb;        // All four bytes
    assign full_rd = ~|mem_fwd.wstrb;
    assign hit     = win_hit && (full_wr || full_rd); // Partial words never claimed
    assign idx     = mem_fwd.addr[IDX_W+1:2];

    // ------------------------------
    // Reply sequencing
    // ------------------------------
    logic        ready_q;   // Reply cycle
    logic        guard_q;   // Cycle after reply, request ignored
    logic [31:0] rdata_q;
    logic [31:0] rd_word;

    // Accept only when neither replying nor in guard
    assign accept = hit && !ready_q && !guard_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= 1'b0;
            guard_q <= 1'b0;
        end else begin
            ready_q <= accept;
            guard_q <= ready_q;
        end
    end

    // Read mux, unmapped words give zero
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < N_REGS; i++) begin
            if (idx == IDX_W'(i)) begin
                rd_word = reg_in[i];
            end
        end
    end

    // Payload, captured on the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= full_rd ? rd_word : 32'h0; // Writes reply with zero
        end
    end

    // Zero outside the reply cycle for the OR combine
    assign mem_ret.ready = ready_q;
    assign mem_ret.rdata = ready_q ? rdata_q : 32'h0;

    // ------------------------------
    // Write strobes
    // ------------------------------
    assign reg_wdata = mem_fwd.wdata;

    always_comb begin
        for (int i = 0; i < N_REGS; i++) begin
            // High in the cycle ending at the accepting edge
            reg_wstrb[i] = accept && full_wr && (idx == IDX_W'(i));
        end
    end

endmodule

// File: testbench/adc_drp_model.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module adc_drp_model (
    input  logic                     clk,
    input  adc_bus_pkg::drp_req_t    drp_req,
    output adc_bus_pkg::drp_rsp_t    drp_rsp,
    input  adc_bus_pkg::adc_status_t status_cfg,   // Fields set by the testbench
    output adc_bus_pkg::adc_status_t adc_status,
    input  logic                     convst,
    input  logic                     adc_reset,
    output int                       reset_count   // Rising edges of adc_reset
);

    import adc_bus_pkg::*;

    localparam int N_DRP = 1 << `ADC_DRP_AW;

    logic [`ADC_DRP_DW-1:0] regs [0:N_DRP-1];
    logic [31:0]            rnd_state = 32'd87;
    logic [2:0]             wait_cnt  = '0;     // Cycles left until drdy
    logic                   dwe_q     = 1'b0;
    logic [`ADC_DRP_AW-1:0] addr_q    = '0;
    logic [`ADC_DRP_DW-1:0] di_q      = '0;
    logic                   drdy_q    = 1'b0;
    logic [`ADC_DRP_DW-1:0] dout_q    = '0;
    logic                   conv_d    = 1'b0;
    logic [2:0]             eoc_pipe  = '0;     // convst edge to eoc delay
    logic                   reset_d   = 1'b0;
    int                     resets    = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // DRP register file
    // ------------------------------
    always @(posedge clk) begin
        drdy_q <= 1'b0;
        if (adc_reset) begin
            for (int i = 0; i < N_DRP; i++) begin
                regs[i] <= '0;                  // Converter reset clears all
            end
            wait_cnt <= '0;
        end else if (drp_req.den) begin
            rnd_state <= xorshift32(rnd_state);
            wait_cnt  <= 3'(rnd_state[1:0]) + 3'd1;     // 1 to 4 cycles
            dwe_q     <= drp_req.dwe;
            addr_q    <= drp_req.daddr;
            di_q      <= drp_req.di;
        end else if (wait_cnt == 3'd1) begin
            drdy_q   <= 1'b1;
            dout_q   <= dwe_q ? '0 : regs[addr_q];
            wait_cnt <= '0;
            if (dwe_q) begin
                regs[addr_q] <= di_q;
            end
        end else if (wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
        end
    end

    assign drp_rsp = {drdy_q, dout_q};

    // Conversion and reset events
    always @(posedge clk) begin
        conv_d  <= convst;
        reset_d <= adc_reset;
        if (adc_reset === 1'b1 && reset_d !== 1'b1) begin
            resets <= resets + 1;
        end
        if (adc_reset) begin
            eoc_pipe <= '0;
        end else begin
            eoc_pipe <= {eoc_pipe[1:0], convst && !conv_d};   // Rising convst
        end
    end

    assign reset_count = resets;

    always_comb begin
        adc_status     = status_cfg;
        adc_status.eoc = eoc_pipe[2];   // Model owns eoc
    end

endmodule

// File: testbench/tb_adc_periph.sv
`timescale 1ns/1ps
`include "adc_bus_config.svh"

module tb_adc_periph;

    import adc_bus_pkg::*;

    localparam int          N_DRP_OPS = 200;
    localparam int          N_XFERS   = N_DRP_OPS + 40;
    localparam int          WD_CYCLES = N_XFERS * 20 + 1000;   // Triggers fit in the margin
    localparam int          ACK_LIMIT = 100;
    localparam logic [31:0] DRP_BASE  = {`ADC_BASE_ADDR, `ADC_WIN_DRP, 16'h0};
    localparam logic [31:0] SFR_BASE  = {`ADC_BASE_ADDR, `ADC_WIN_SFR, 16'h0};

    logic        clk;
    logic        rst;
    logic        trigger_in;
    mem_fwd_t    mem_fwd;
    mem_ret_t    mem_ret;
    drp_req_t    drp_req;
    drp_rsp_t    drp_rsp;
    adc_status_t adc_status;
    adc_status_t status_cfg;
    logic        convst;
    logic        adc_reset;
    int          reset_count;
    logic [31:0] rng = 32'd87;
    logic [15:0] shadow [0:127] = '{default: '0};    // Last DRP write per address
    int          err_count = 0;

    adc_periph adc_periph_i (.*);

    adc_drp_model drp_model_i (
        .clk         (clk),
        .drp_req     (drp_req),
        .drp_rsp     (drp_rsp),
        .status_cfg  (status_cfg),
        .adc_status  (adc_status),
        .convst      (convst),
        .adc_reset   (adc_reset),
        .reset_count (reset_count)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Word 0 layout from the register map
    function automatic logic [31:0] status_word(input adc_status_t s);
        logic [31:0] w;
        w        = '0;
        w[0]     = s.busy;
        w[1]     = s.eoc;
        w[2]     = s.eos;
        w[3]     = s.ot;
        w[12:8]  = s.channel;
        w[23:16] = s.alm;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("%s, at %0t", msg, $time);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // One request, held until ready or until limit cycles pass
    task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input int limit,
                            output logic [31:0] rdata, output logic acked);
        int n;
        n = 0;
        @(negedge clk);
        mem_fwd.valid = 1'b1;
        mem_fwd.addr  = addr;
        mem_fwd.wdata = wdata;
        mem_fwd.wstrb = wstrb;
        do begin
            @(negedge clk);     // ready is stable mid-cycle
            n++;
        end while (!mem_ret.ready && n < limit);
        acked   = mem_ret.ready;
        rdata   = mem_ret.rdata;
        mem_fwd = '0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        ack;
        bus_xfer(addr, wdata, 4'hf, ACK_LIMIT, rd, ack);
        if (!ack) begin
            report_error($sformatf("No bus reply to write at 0x%h", addr));
        end
        check_value("write rdata", rd, 32'h0);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
        logic ack;
        bus_xfer(addr, 32'h0, 4'h0, ACK_LIMIT, rdata, ack);
        if (!ack) begin
            report_error($sformatf("No bus reply to read at 0x%h", addr));
        end
    endtask

    task automatic pulse_trigger(input int gap);
        @(negedge clk);
        trigger_in = 1'b1;
        repeat (2) @(negedge clk);
        trigger_in = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // ------------------------------
    // Clock and watchdog
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the test did not finish", WD_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [6:0]  a;
        logic        ack;
        int          n;
        int          resets_before;
        adc_status_t s;
        rst        = 1'b1;
        trigger_in = 1'b0;
        mem_fwd    = '0;
        status_cfg = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("adc_reset", 32'(adc_reset), 32'h1);   // Held with rst
        rst = 1'b0;
        @(negedge clk);                 // adc_reset drops one edge later
        check_value("den", 32'(drp_req.den), 32'h0);
        check_value("ready", 32'(mem_ret.ready), 32'h0);
        check_value("convst", 32'(convst), 32'h0);
        check_value("adc_reset", 32'(adc_reset), 32'h0);
        bus_read(SFR_BASE, rd);
        check_value("status", rd, 32'h0);
        bus_read(SFR_BASE + 32'h4, rd);
        check_value("count", rd, 32'h0);
        bus_read(SFR_BASE + 32'h8, rd);
        check_value("control", rd, 32'h0);

        // Random DRP traffic over 32 addresses for frequent hits
        for (int i = 0; i < N_DRP_OPS; i++) begin
            r = next_random();
            a = {2'b00, r[8:4]};
            if (r[0]) begin
                bus_write(DRP_BASE | {23'h0, a, 2'b00}, r[31:0] ^ {r[15:0], 16'h0});
                shadow[a] = r[15:0];    // Upper wdata bits ignored
            end else begin
                bus_read(DRP_BASE | {23'h0, a, 2'b00}, rd);
                check_value("drp rdata", rd, {16'h0, shadow[a]});
            end
        end

        // Status fields, eoc left to the model
        for (int i = 0; i < 8; i++) begin
            s     = adc_status_t'(next_random());
            s.eoc = 1'b0;
            @(negedge clk);
            status_cfg = s;
            bus_read(SFR_BASE, rd);
            check_value("status", rd, status_word(s));
        end
        status_cfg = '0;

        // Trigger blocked by control enable
        for (int i = 0; i < 3; i++) begin
            pulse_trigger(8);
        end
        bus_read(SFR_BASE + 32'h4, rd);
        check_value("count", rd, 32'h0);
        bus_write(SFR_BASE + 32'h8, 32'h1);
        bus_read(SFR_BASE + 32'h8, rd);
        check_value("control", rd, 32'h1);
        n = 1 + int'(next_random() % 6);
        for (int i = 0; i < n; i++) begin
            pulse_trigger(8 + int'(next_random() % 5));
        end
        repeat (8) @(negedge clk);
        bus_read(SFR_BASE + 32'h4, rd);
        check_value("count", rd, 32'(n));
        bus_read(SFR_BASE + 32'hc, rd);                 // Word past the bank
        check_value("unmapped word", rd, 32'h0);
        bus_write(SFR_BASE + 32'h4, next_random());     // Any value clears
        bus_read(SFR_BASE + 32'h4, rd);
        check_value("count", rd, 32'h0);
        bus_write(SFR_BASE + 32'h8, 32'h0);
        bus_read(SFR_BASE + 32'h8, rd);
        check_value("control", rd, 32'h0);

        // Soft reset wipes the converter registers
        bus_write(DRP_BASE | 32'h14, 32'h0000_a5a5);
        bus_read(DRP_BASE | 32'h14, rd);
        check_value("drp rdata", rd, 32'h0000_a5a5);
        resets_before = reset_count;
        bus_write(SFR_BASE, 32'h1);
        check_value("adc_reset", 32'(adc_reset), 32'h1);   // High in the reply cycle
        @(negedge clk);
        check_value("adc_reset", 32'(adc_reset), 32'h0);   // One cycle only
        check_value("reset_count", 32'(reset_count - resets_before), 32'h1);
        shadow = '{default: '0};
        bus_read(DRP_BASE | 32'h14, rd);
        check_value("drp rdata", rd, {16'h0, shadow[5]});

        // Unclaimed requests, no ready expected
        bus_xfer(32'h0200_0000, 32'h0, 4'h0, 20, rd, ack);
        check_value("ready", 32'(ack), 32'h0);
        bus_xfer({`ADC_BASE_ADDR, 8'h20, 16'h0}, 32'h0, 4'h0, 20, rd, ack);
        check_value("ready", 32'(ack), 32'h0);
        bus_xfer(SFR_BASE + 32'h8, 32'hffff_ffff, 4'b0011, 20, rd, ack);   // Partial word
        check_value("ready", 32'(ack), 32'h0);
        bus_read(SFR_BASE + 32'h8, rd);
        check_value("control", rd, 32'h0);

        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
